// File: hw/dbg_ahb_pkg.sv
// Shared bus widths, AHB encodings, debug size codes, SRAM geometry and wait states
`default_nettype none

package dbg_ahb_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Address and data widths, data fixed at 32 bits
  localparam int addr_width = 32;
  localparam int data_width = 32;

  //////////////////////////////////////////////////
  // Debug port word-size codes
  //////////////////////////////////////////////////

  // Any other code on the 4-bit field is a word access
  localparam logic [3:0] size_byte  = 4'd1;
  localparam logic [3:0] size_hword = 4'd2;
  localparam logic [3:0] size_word  = 4'd4;

  //////////////////////////////////////////////////
  // AHB-Lite encodings
  //////////////////////////////////////////////////

  localparam logic [2:0] hsize_byte  = 3'd0;
  localparam logic [2:0] hsize_hword = 3'd1;
  localparam logic [2:0] hsize_word  = 3'd2;

  localparam logic [1:0] htrans_idle   = 2'd0;
  localparam logic [1:0] htrans_nonseq = 2'd2;

  localparam logic [2:0] hburst_single = 3'd0;

  // Data access, privileged, non-bufferable, non-cacheable
  localparam logic [3:0] hprot_dbg = 4'b0011;

  localparam logic hresp_okay  = 1'b0;
  localparam logic hresp_error = 1'b1;

  //////////////////////////////////////////////////
  // SRAM geometry and timing
  //////////////////////////////////////////////////

  // 256 words of 32 bits, 1 KiB
  localparam int sram_words     = 256;
  localparam int sram_idx_width = $clog2(sram_words);
  localparam logic [addr_width-1:0] sram_bytes = addr_width'(sram_words * 4);

  // Data-phase wait cycles before HREADY goes high
  localparam int sram_wait_states = 2;
  localparam int sram_wait_width  = $clog2(sram_wait_states + 1);
  localparam logic [sram_wait_width-1:0] sram_wait_last = sram_wait_width'(sram_wait_states);

endpackage

`default_nettype wire

// File: hw/dbg_req_capture.sv
// Debug-domain request latch, write-lane replication, start toggle and ready flag
`timescale 1ns/1ns
`default_nettype none

module dbg_req_capture (
  input  wire                                   dbg_clk,
  input  wire                                   ahb_rstn,
  input  wire  [dbg_ahb_pkg::data_width-1:0]    dbg_di,
  input  wire  [dbg_ahb_pkg::addr_width-1:0]    dbg_addr,
  input  wire                                   dbg_strb,
  input  wire                                   dbg_rw,
  input  wire  [3:0]                            dbg_word_size,
  input  wire                                   done_pulse,
  output logic                                  dbg_rdy,
  output logic [dbg_ahb_pkg::addr_width-1:0]    haddr,
  output logic [dbg_ahb_pkg::data_width-1:0]    hwdata,
  output logic                                  hwrite,
  output logic [2:0]                            hsize,
  output logic                                  start_tgl
);

  // Request accepted only while idle
  logic accept;

  assign accept = dbg_strb && dbg_rdy;

  //////////////////////////////////////////////////
  // Request payload
  //////////////////////////////////////////////////

  // Held stable for the whole AHB transfer
  always_ff @(posedge dbg_clk) begin
    if (accept) begin
      haddr  <= dbg_addr;
      // rw is 1 for read, AHB wants 1 for write
      hwrite <= ~dbg_rw;
      case (dbg_word_size)
        dbg_ahb_pkg::size_byte: begin
          hsize  <= dbg_ahb_pkg::hsize_byte;
          // Top byte copied to every lane
          hwdata <= {4{dbg_di[31:24]}};
        end
        dbg_ahb_pkg::size_hword: begin
          hsize  <= dbg_ahb_pkg::hsize_hword;
          hwdata <= {2{dbg_di[31:16]}};
        end
        default: begin
          hsize  <= dbg_ahb_pkg::hsize_word;
          hwdata <= dbg_di;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Start toggle and ready
  //////////////////////////////////////////////////

  always_ff @(posedge dbg_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      start_tgl <= 1'b0;
      dbg_rdy   <= 1'b1;
    end else begin
      // One flip per accepted request
      if (accept) begin
        start_tgl <= ~start_tgl;
      end
      // Drop on accept, raise when the done toggle arrives
      if (accept) begin
        dbg_rdy <= 1'b0;
      end else if (done_pulse) begin
        dbg_rdy <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/dbg_toggle_sync.sv
// Two-flop toggle synchronizer producing a one-cycle pulse per input toggle
`timescale 1ns/1ns
`default_nettype none

module dbg_toggle_sync (
  input  wire  clk,
  input  wire  ahb_rstn,
  input  wire  tgl_in,
  output logic pulse
);

  // First stage may go metastable
  logic sync_ff1;
  // Settled copy of the toggle level
  logic sync_ff2;
  // Previous settled level, for edge detect
  logic sync_ff2_q;

  //////////////////////////////////////////////////
  // Synchronizer chain
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      sync_ff1   <= 1'b0;
      sync_ff2   <= 1'b0;
      sync_ff2_q <= 1'b0;
    end else begin
      sync_ff1   <= tgl_in;
      sync_ff2   <= sync_ff1;
      sync_ff2_q <= sync_ff2;
    end
  end

  // Either edge of the toggle gives one pulse
  assign pulse = sync_ff2 ^ sync_ff2_q;

endmodule

`default_nettype wire

// File: hw/dbg_ahb_master.sv
// AHB-Lite master FSM for single transfers with request hold, error capture and done toggle
`timescale 1ns/1ns
`default_nettype none

module dbg_ahb_master (
  input  wire         HCLK,
  input  wire         ahb_rstn,
  input  wire         start_pulse,
  input  wire         HREADY,
  input  wire         HRESP,
  output logic        HSEL,
  output logic [1:0]  HTRANS,
  output logic [2:0]  HBURST,
  output logic [3:0]  HPROT,
  output logic        HMASTLOCK,
  output logic        xfer_ack,
  output logic        done_tgl,
  output logic        dbg_err
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_t;

  state_t state;
  // Start seen while a transfer was still running
  logic   start_hold;
  logic   start_req;

  //////////////////////////////////////////////////
  // Fixed transfer attributes
  //////////////////////////////////////////////////

  // Only singles, never locked
  assign HBURST    = dbg_ahb_pkg::hburst_single;
  assign HPROT     = dbg_ahb_pkg::hprot_dbg;
  assign HMASTLOCK = 1'b0;

  // Slave selected from address phase through data phase
  assign HSEL = (state != st_idle);

  // Data phase ends on the first HREADY high
  assign xfer_ack = (state == st_data) && HREADY;

  assign start_req = start_pulse || start_hold;

  //////////////////////////////////////////////////
  // Transfer FSM
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      state      <= st_idle;
      HTRANS     <= dbg_ahb_pkg::htrans_idle;
      start_hold <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          start_hold <= 1'b0;
          if (start_req) begin
            // Address phase on the next cycle
            HTRANS <= dbg_ahb_pkg::htrans_nonseq;
            state  <= st_addr;
          end
        end
        st_addr: begin
          start_hold <= start_req;
          HTRANS     <= dbg_ahb_pkg::htrans_idle;
          state      <= st_data;
        end
        st_data: begin
          start_hold <= start_req;
          if (HREADY) begin
            state <= st_idle;
          end
        end
        default: begin
          HTRANS <= dbg_ahb_pkg::htrans_idle;
          state  <= st_idle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Completion status
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dbg_err  <= 1'b0;
      done_tgl <= 1'b0;
    end else if (xfer_ack) begin
      dbg_err  <= (HRESP == dbg_ahb_pkg::hresp_error);
      done_tgl <= ~done_tgl;
    end
  end

endmodule

`default_nettype wire

// File: hw/dbg_ahb_sram.sv
// AHB-Lite SRAM slave with byte-lane writes, fixed wait states and range error
`timescale 1ns/1ns
`default_nettype none

module dbg_ahb_sram (
  input  wire                                   HCLK,
  input  wire                                   ahb_rstn,
  input  wire                                   HSEL,
  input  wire  [dbg_ahb_pkg::addr_width-1:0]    haddr,
  input  wire  [1:0]                            HTRANS,
  input  wire                                   hwrite,
  input  wire  [2:0]                            hsize,
  input  wire  [dbg_ahb_pkg::data_width-1:0]    hwdata,
  output logic [dbg_ahb_pkg::data_width-1:0]    HRDATA,
  output logic                                  HREADY,
  output logic                                  HRESP
);

  logic [dbg_ahb_pkg::data_width-1:0] mem [dbg_ahb_pkg::sram_words];

  logic                                      addr_valid;
  logic [3:0]                                addr_be;
  // Data-phase copy of the address phase
  logic                                      dp_active;
  logic                                      dp_write;
  logic                                      dp_err;
  logic [3:0]                                dp_be;
  logic [dbg_ahb_pkg::sram_idx_width-1:0]    dp_idx;
  logic [dbg_ahb_pkg::sram_wait_width-1:0]   wait_cnt;
  logic                                      dp_done;

  // Our own HREADY doubles as HREADYIN, single slave
  assign addr_valid = HSEL && (HTRANS == dbg_ahb_pkg::htrans_nonseq) && HREADY;

  // Little-endian lane enables
  always_comb begin
    case (hsize)
      dbg_ahb_pkg::hsize_byte:  addr_be = 4'b0001 << haddr[1:0];
      dbg_ahb_pkg::hsize_hword: addr_be = haddr[1] ? 4'b1100 : 4'b0011;
      default:                  addr_be = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////
  // Address phase capture and wait counter
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dp_active <= 1'b0;
      wait_cnt  <= '0;
    end else begin
      if (HREADY) begin
        dp_active <= addr_valid;
      end
      if (addr_valid) begin
        wait_cnt <= '0;
      end else if (dp_active && !HREADY) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge HCLK) begin
    if (addr_valid) begin
      dp_write <= hwrite;
      dp_be    <= addr_be;
      dp_idx   <= haddr[dbg_ahb_pkg::sram_idx_width+1:2];
      // Outside the 1 KiB window
      dp_err   <= (haddr >= dbg_ahb_pkg::sram_bytes);
    end
  end

  //////////////////////////////////////////////////
  // Response and data
  //////////////////////////////////////////////////

  assign HREADY  = !dp_active || (wait_cnt == dbg_ahb_pkg::sram_wait_last);
  assign dp_done = dp_active && HREADY;

  // Two-cycle error, HRESP leads HREADY by one cycle
  assign HRESP = (dp_active && dp_err && (wait_cnt >= dbg_ahb_pkg::sram_wait_last - 1'b1))
                 ? dbg_ahb_pkg::hresp_error : dbg_ahb_pkg::hresp_okay;

  // Zero unless a good read completes
  assign HRDATA = (dp_done && !dp_write && !dp_err) ? mem[dp_idx] : '0;

  always_ff @(posedge HCLK) begin
    if (dp_done && dp_write && !dp_err) begin
      for (int i = 0; i < 4; i++) begin
        if (dp_be[i]) begin
          mem[dp_idx][8*i +: 8] <= hwdata[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/dbg_rdata_align.sv
// Read-data register with byte and halfword extraction into the low bits
`timescale 1ns/1ns
`default_nettype none

module dbg_rdata_align #(
  parameter int little_endian = 1
) (
  input  wire                                   HCLK,
  input  wire                                   xfer_ack,
  input  wire  [dbg_ahb_pkg::data_width-1:0]    HRDATA,
  input  wire  [dbg_ahb_pkg::addr_width-1:0]    haddr,
  input  wire  [2:0]                            hsize,
  output logic [dbg_ahb_pkg::data_width-1:0]    dbg_do
);

  // Lane numbers counted from bit 0 of HRDATA
  logic [1:0] byte_lane;
  logic       hword_lane;

  //////////////////////////////////////////////////
  // Lane selection
  //////////////////////////////////////////////////

  // Big-endian puts address 0 in the top lane
  assign byte_lane  = (little_endian != 0) ? haddr[1:0] : ~haddr[1:0];
  assign hword_lane = (little_endian != 0) ? haddr[1] : ~haddr[1];

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  // Updated only on the completing data-phase cycle
  always_ff @(posedge HCLK) begin
    if (xfer_ack) begin
      case (hsize)
        dbg_ahb_pkg::hsize_byte: begin
          // Zero-extended byte
          dbg_do <= {24'h0, HRDATA[8*byte_lane +: 8]};
        end
        dbg_ahb_pkg::hsize_hword: begin
          // Zero-extended halfword
          dbg_do <= {16'h0, HRDATA[16*hword_lane +: 16]};
        end
        default: begin
          dbg_do <= HRDATA;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/dbg_ahb_subsys.sv
// Debug bus access top level joining capture, synchronizers, AHB master, SRAM and alignment
`timescale 1ns/1ns
`default_nettype none

module dbg_ahb_subsys #(
  parameter int little_endian = 1
) (
  input  wire                                   dbg_clk,
  input  wire                                   HCLK,
  input  wire                                   ahb_rstn,
  input  wire  [dbg_ahb_pkg::data_width-1:0]    dbg_di,
  input  wire  [dbg_ahb_pkg::addr_width-1:0]    dbg_addr,
  input  wire                                   dbg_strb,
  input  wire                                   dbg_rw,
  input  wire  [3:0]                            dbg_word_size,
  output logic [dbg_ahb_pkg::data_width-1:0]    dbg_do,
  output logic                                  dbg_rdy,
  output logic                                  dbg_err
);

  // Latched request, debug domain
  logic [dbg_ahb_pkg::addr_width-1:0] haddr;
  logic [dbg_ahb_pkg::data_width-1:0] hwdata;
  logic                               hwrite;
  logic [2:0]                         hsize;
  logic                               start_tgl;
  logic                               done_pulse;

  // HCLK domain
  logic                               start_pulse;
  logic                               HSEL;
  logic [1:0]                         HTRANS;
  logic [dbg_ahb_pkg::data_width-1:0] HRDATA;
  logic                               HREADY;
  logic                               HRESP;
  logic                               xfer_ack;
  logic                               done_tgl;

  //////////////////////////////////////////////////
  // Debug side
  //////////////////////////////////////////////////

  dbg_req_capture dbg_req_capture_inst (
    .dbg_clk, .ahb_rstn, .dbg_di, .dbg_addr, .dbg_strb, .dbg_rw, .dbg_word_size,
    .done_pulse, .dbg_rdy, .haddr, .hwdata, .hwrite, .hsize, .start_tgl
  );

  // Start request into HCLK
  dbg_toggle_sync start_sync_inst (
    .clk (HCLK), .ahb_rstn, .tgl_in (start_tgl), .pulse (start_pulse)
  );

  // Completion back into dbg_clk
  dbg_toggle_sync done_sync_inst (
    .clk (dbg_clk), .ahb_rstn, .tgl_in (done_tgl), .pulse (done_pulse)
  );

  //////////////////////////////////////////////////
  // AHB side
  //////////////////////////////////////////////////

  // Burst, protection and lock are fixed and the SRAM ignores them
  dbg_ahb_master dbg_ahb_master_inst (
    .HCLK, .ahb_rstn, .start_pulse, .HREADY, .HRESP, .HSEL, .HTRANS,
    .HBURST (), .HPROT (), .HMASTLOCK (), .xfer_ack, .done_tgl, .dbg_err
  );

  dbg_ahb_sram dbg_ahb_sram_inst (
    .HCLK, .ahb_rstn, .HSEL, .haddr, .HTRANS, .hwrite, .hsize, .hwdata,
    .HRDATA, .HREADY, .HRESP
  );

  dbg_rdata_align #(
    .little_endian (little_endian)
  ) dbg_rdata_align_inst (
    .HCLK, .xfer_ack, .HRDATA, .haddr, .hsize, .dbg_do
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// Testbench clock generator with an active-low reset held for a number of cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst_n
);

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

  // Release a quarter period after the last counted rising edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #(period_ns / 4);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_dbg_ahb_subsys.sv
// Testbench top: loads cases, drives debug requests, checks read data and error, watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_dbg_ahb_subsys;

  // HCLK cycles allowed per case before the run counts as hung
  localparam int cycles_per_case = 100;
  localparam cases_path = "test/dbg_ahb_cases.txt";

  // Operation codes of the cases file
  localparam int op_write      = 0;
  localparam int op_read       = 1;
  localparam int op_write_busy = 2;

  logic                               HCLK;
  logic                               dbg_clk;
  logic                               ahb_rstn;
  logic [dbg_ahb_pkg::data_width-1:0] dbg_di;
  logic [dbg_ahb_pkg::addr_width-1:0] dbg_addr;
  logic                               dbg_strb;
  logic                               dbg_rw;
  logic [3:0]                         dbg_word_size;
  logic [dbg_ahb_pkg::data_width-1:0] dbg_do;
  logic                               dbg_rdy;
  logic                               dbg_err;

  // Case table, one entry per data line
  string       case_name [$];
  int          case_op [$];
  int          case_size [$];
  logic [31:0] case_addr [$];
  logic [31:0] case_wdata [$];
  logic [31:0] case_rdata [$];
  logic        case_err [$];

  int   pass_count;
  int   fail_count;
  int   cycle_limit;
  int   cycle_cnt;
  logic load_ok;

  //////////////////////////////////////////////////
  // Clocks, reset and DUT
  //////////////////////////////////////////////////

  tb_clk_gen #(.period_ns (10), .reset_cycles (10)) hclk_gen_inst (
    .clk (HCLK), .rst_n (ahb_rstn)
  );

  // Unrelated period for the debug side, its reset output unused
  tb_clk_gen #(.period_ns (26), .reset_cycles (10)) dbg_clk_gen_inst (
    .clk (dbg_clk), .rst_n ()
  );

  dbg_ahb_subsys #(.little_endian (1)) dbg_ahb_subsys_inst (
    .dbg_clk, .HCLK, .ahb_rstn, .dbg_di, .dbg_addr, .dbg_strb, .dbg_rw,
    .dbg_word_size, .dbg_do, .dbg_rdy, .dbg_err
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic load_cases;
    int          fd;
    int          n;
    string       line;
    string       name;
    int          op;
    int          size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    int          err;
    fd = $fopen(cases_path, "r");
    if (fd == 0) begin
      $display("Could not open %s for reading", cases_path);
      load_ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Skip comment and blank lines
        if (n > 0 && line.getc(0) != "#") begin
          if ($sscanf(line, "%s %d %d %h %h %h %d",
                      name, op, size, addr, wdata, rdata, err) == 7) begin
            case_name.push_back(name);
            case_op.push_back(op);
            case_size.push_back(size);
            case_addr.push_back(addr);
            case_wdata.push_back(wdata);
            case_rdata.push_back(rdata);
            case_err.push_back(err != 0);
          end
        end
      end
      $fclose(fd);
      load_ok = (case_name.size() > 0);
      if (!load_ok) begin
        $display("No test cases found in %s", cases_path);
      end
    end
  endtask

  // Called 1 ns after a dbg_clk rising edge, returns at the same point
  task automatic wait_ready;
    while (dbg_rdy !== 1'b1) begin
      @(posedge dbg_clk);
      #1;
    end
  endtask

  task automatic drive_request(input int op, input int size, input logic [31:0] addr,
                               input logic [31:0] wdata);
    dbg_strb      = 1'b1;
    dbg_rw        = (op == op_read);
    dbg_word_size = 4'(size);
    dbg_addr      = addr;
    dbg_di        = wdata;
  endtask

  task automatic record_result(input string name, input int errors);
    if (errors == 0) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic check_reset_state;
    int errors;
    errors = 0;
    if (dbg_rdy !== 1'b1) begin
      $display("ERROR reset_state: dbg_rdy expected 1 actual %b", dbg_rdy);
      errors++;
    end
    if (dbg_err !== 1'b0) begin
      $display("ERROR reset_state: dbg_err expected 0 actual %b", dbg_err);
      errors++;
    end
    record_result("reset_state", errors);
  endtask

  task automatic run_case(input int idx);
    int errors;
    errors = 0;
    wait_ready();
    drive_request(case_op[idx], case_size[idx], case_addr[idx], case_wdata[idx]);
    // Accepted on this edge since dbg_rdy is high
    @(posedge dbg_clk);
    #1;
    dbg_strb = 1'b0;
    if (dbg_rdy !== 1'b0) begin
      $display("%s: dbg_rdy stayed high after an accepted strobe", case_name[idx]);
      errors++;
    end
    // Conflicting write while busy, must be dropped
    if (case_op[idx] == op_write_busy) begin
      drive_request(op_write, case_size[idx], case_addr[idx], ~case_wdata[idx]);
      repeat (2) begin
        @(posedge dbg_clk);
        #1;
      end
      dbg_strb = 1'b0;
    end
    wait_ready();
    if (case_op[idx] == op_read && dbg_do !== case_rdata[idx]) begin
      $display("ERROR %s: dbg_do expected %h actual %h",
               case_name[idx], case_rdata[idx], dbg_do);
      errors++;
    end
    if (dbg_err !== case_err[idx]) begin
      $display("ERROR %s: dbg_err expected %b actual %b",
               case_name[idx], case_err[idx], dbg_err);
      errors++;
    end
    record_result(case_name[idx], errors);
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge HCLK);
      cycle_cnt++;
    end
    $display("Timeout: run hung waiting for dbg_rdy after %0d HCLK cycles", cycle_limit);
    $display("Testbench failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    dbg_di        = '0;
    dbg_addr      = '0;
    dbg_strb      = 1'b0;
    dbg_rw        = 1'b1;
    dbg_word_size = dbg_ahb_pkg::size_word;
    pass_count    = 0;
    fail_count    = 0;
    cycle_limit   = 0;
    load_cases();
    if (!load_ok) begin
      fail_count++;
    end else begin
      cycle_limit = case_name.size() * cycles_per_case;
      wait (ahb_rstn === 1'b1);
      @(posedge dbg_clk);
      #1;
      check_reset_state();
      // Each request goes out as soon as dbg_rdy is back
      for (int i = 0; i < case_name.size(); i++) begin
        run_case(i);
      end
    end
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dbg_ahb_subsys.f
hw/dbg_ahb_pkg.sv
hw/dbg_req_capture.sv
hw/dbg_toggle_sync.sv
hw/dbg_ahb_master.sv
hw/dbg_ahb_sram.sv
hw/dbg_rdata_align.sv
hw/dbg_ahb_subsys.sv
test/tb_clk_gen.sv
test/tb_dbg_ahb_subsys.sv

// File: Bender.yml
package:
  name: dbg_ahb_subsys

sources:
  - hw/dbg_ahb_pkg.sv
  - hw/dbg_req_capture.sv
  - hw/dbg_toggle_sync.sv
  - hw/dbg_ahb_master.sv
  - hw/dbg_ahb_sram.sv
  - hw/dbg_rdata_align.sv
  - hw/dbg_ahb_subsys.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_dbg_ahb_subsys.sv

// File: test/dbg_ahb_cases.txt
# name op size addr wdata exp_rdata exp_err   (hex for addr and data)
# op: 0 write, 1 read, 2 write plus an ignored strobe while busy; size: 1 byte, 2 hword, 4 word
wr_word_10   0 4 00000010 A1B2C3D4 00000000 0
rd_word_10   1 4 00000010 00000000 A1B2C3D4 0
wr_word_20   0 4 00000020 11223344 00000000 0
wr_byte_0    0 1 00000020 AA5A5A5A 00000000 0
rd_word_b0   1 4 00000020 00000000 112233AA 0
wr_byte_1    0 1 00000021 BB123456 00000000 0
wr_byte_2    0 1 00000022 CC654321 00000000 0
wr_byte_3    0 1 00000023 DD0F0F0F 00000000 0
rd_word_b3   1 4 00000020 00000000 DDCCBBAA 0
rd_byte_1    1 1 00000021 00000000 000000BB 0
rd_byte_3    1 1 00000023 00000000 000000DD 0
wr_word_30   0 4 00000030 55667788 00000000 0
wr_hword_0   0 2 00000030 BEEF1234 00000000 0
rd_hword_0   1 2 00000030 00000000 0000BEEF 0
wr_hword_2   0 2 00000032 CAFE9876 00000000 0
rd_hword_2   1 2 00000032 00000000 0000CAFE 0
rd_word_30   1 4 00000030 00000000 CAFEBEEF 0
wr_word_00   0 4 00000000 0BADF00D 00000000 0
wr_oor_400   0 4 00000400 DEADBEEF 00000000 1
rd_oor_400   1 4 00000400 00000000 00000000 1
rd_word_00   1 4 00000000 00000000 0BADF00D 0
rd_oor_high  1 4 80000000 00000000 00000000 1
rd_word_10b  1 4 00000010 00000000 A1B2C3D4 0
wr_busy_40   2 4 00000040 13579BDF 00000000 0
rd_word_40   1 4 00000040 00000000 13579BDF 0
